// ==== mips_control_top.f ====
+incdir+include
logic/mips_control_pkg.sv
logic/instr_decoder.sv
logic/state_sequencer.sv
logic/control_word_gen.sv
logic/mips_control_top.sv
verification/mips_control_checks.sv
verification/tb_mips_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the control unit with its testbench, run it, and judge the run by its output
cd "$(dirname "$0")" \
    && verilator --binary --assert --timing --top-module tb_mips_control -f mips_control_top.f \
    && ./obj_dir/Vtb_mips_control | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
exit 0

// ==== verification/tb_mips_control.sv ====
`timescale 1ns/1ns
`include "mips_control_consts.svh"

module tb_mips_control;

    import mips_control_pkg::*;

    // Twenty of each class, the remainder drawn at random
    localparam int PER_CLASS = 20;
    localparam int N_INSTR   = 160;

    logic                 clk;
    logic                 reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic                 zero;
    ctrl_word_t           ctrl;
    logic                 illegal_instr;
    int                   errors;
    logic [2:0]           class_q [$];
    int                   class_count [8];

    mips_control_top mips_control_top_i
    (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .ctrl          (ctrl),
        .illegal_instr (illegal_instr)
    );

    mips_control_checks checks_i
    (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .ctrl          (ctrl),
        .illegal_instr (illegal_instr),
        .errors        (errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Budget of five cycles per instruction plus start-up margin
    initial
    begin
        #(N_INSTR * 5 * 10 + 200);
        $display("Watchdog expired before all instructions completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Class order as a shuffled list so that every class gets its quota
    task automatic build_class_order();
        logic [2:0] tmp;
        int         j;
        for (int c = 0; c < 7; c++)
            for (int k = 0; k < PER_CLASS; k++)
                class_q.push_back(3'(c));
        while (class_q.size() < N_INSTR)
            class_q.push_back(3'($urandom_range(0, 6)));
        for (int i = N_INSTR - 1; i > 0; i--)
        begin
            j = $urandom_range(0, i);
            tmp = class_q[i];
            class_q[i] = class_q[j];
            class_q[j] = tmp;
        end
    endtask

    // Steps one clock at a time until the DUT is in a fetch cycle
    task automatic wait_fetch();
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!ctrl.ir_write);
    endtask

    // Drives a random opcode and funct of the given class plus a random zero flag
    task automatic present_instr(input instr_class_e cls);
        logic [`OPCODE_W-1:0] op;
        logic [`FUNCT_W-1:0]  fn;
        op = `OP_RTYPE;
        fn = 6'($urandom_range(0, 63));
        case (cls)
            CLASS_ALU:
            begin
                case ($urandom_range(0, 9))
                    0: fn = `FN_ADD;
                    1: fn = `FN_SUB;
                    2: fn = `FN_AND;
                    3: fn = `FN_OR;
                    4: fn = `FN_SLT;
                    5: op = `OP_ADDI;
                    6: op = `OP_SLTI;
                    7: op = `OP_ANDI;
                    8: op = `OP_ORI;
                    default: op = `OP_LUI;
                endcase
            end
            CLASS_LOAD:  op = `OP_LW;
            CLASS_STORE: op = `OP_SW;
            CLASS_BEQ:   op = `OP_BEQ;
            CLASS_BNE:   op = `OP_BNE;
            CLASS_JUMP:  op = `OP_J;
            default:
            begin
                // Half are R-type with an unknown funct, half an unknown primary opcode
                do
                begin
                    op = ($urandom_range(0, 1) == 0) ? `OP_RTYPE : 6'($urandom_range(0, 63));
                    fn = 6'($urandom_range(0, 63));
                end
                while ((op inside {`OP_J, `OP_BEQ, `OP_BNE, `OP_ADDI, `OP_SLTI, `OP_ANDI,
                                   `OP_ORI, `OP_LUI, `OP_LW, `OP_SW})
                       || (op == `OP_RTYPE
                           && (fn inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT})));
            end
        endcase
        opcode = op;
        funct  = fn;
        zero   = 1'($urandom_range(0, 1));
    endtask

    initial
    begin
        instr_class_e cls;
        int           prev_errors;
        reset  = 1'b0;
        opcode = '0;
        funct  = '0;
        zero   = 1'b0;
        cls    = CLASS_UNDEF;
        void'($urandom(32'hc75af5d2));
        build_class_order();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b1;
        prev_errors = 0;
        // Each fetch closes the previous instruction and opens the next one
        for (int i = 0; i <= N_INSTR; i++)
        begin
            wait_fetch();
            if (i > 0)
            begin
                $display("instr %0d %s opcode %0d funct %0d zero %0b: %s", i - 1, cls.name(),
                         opcode, funct, zero, (errors == prev_errors) ? "ok" : "failed");
                prev_errors = errors;
            end
            if (i < N_INSTR)
            begin
                cls = instr_class_e'(class_q[i]);
                class_count[cls] = class_count[cls] + 1;
                present_instr(cls);
            end
        end
        $display("Done: %0d instr, alu %0d lw %0d sw %0d beq %0d bne %0d j %0d undef %0d, errors %0d",
                 N_INSTR, class_count[CLASS_ALU], class_count[CLASS_LOAD],
                 class_count[CLASS_STORE], class_count[CLASS_BEQ], class_count[CLASS_BNE],
                 class_count[CLASS_JUMP], class_count[CLASS_UNDEF], errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/mips_control_checks.sv ====
`timescale 1ns/1ns
`include "mips_control_consts.svh"

// Watches the ports of the control unit and checks each cycle against the instruction
// that was fetched a known number of cycles earlier
module mips_control_checks
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`OPCODE_W-1:0]         opcode,
    input  logic [`FUNCT_W-1:0]          funct,
    input  logic                         zero,
    input  mips_control_pkg::ctrl_word_t ctrl,
    input  logic                         illegal_instr,
    output int                           errors
);

    import mips_control_pkg::*;

    initial errors = 0;

    task automatic report_mismatch(input string msg);
        errors = errors + 1;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    // R-type with one of the five implemented funct codes
    function automatic logic rtype_ok(input logic [`OPCODE_W-1:0] op,
                                      input logic [`FUNCT_W-1:0] fn);
        return (op == `OP_RTYPE) && (fn inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT});
    endfunction

    function automatic logic alu_instr(input logic [`OPCODE_W-1:0] op,
                                       input logic [`FUNCT_W-1:0] fn);
        return rtype_ok(op, fn) || (op inside {`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI});
    endfunction

    function automatic logic defined_instr(input logic [`OPCODE_W-1:0] op,
                                           input logic [`FUNCT_W-1:0] fn);
        return alu_instr(op, fn) || (op inside {`OP_LW, `OP_SW, `OP_BEQ, `OP_BNE, `OP_J});
    endfunction

    // ALU operation named by the mnemonic, add when nothing else matches
    function automatic alu_op_e expected_alu_op(input logic [`OPCODE_W-1:0] op,
                                                input logic [`FUNCT_W-1:0] fn);
        if (op == `OP_RTYPE && fn == `FN_SUB)
            return ALU_SUB;
        if (op == `OP_ANDI || (op == `OP_RTYPE && fn == `FN_AND))
            return ALU_AND;
        if (op == `OP_ORI || (op == `OP_RTYPE && fn == `FN_OR))
            return ALU_OR;
        if (op == `OP_SLTI || (op == `OP_RTYPE && fn == `FN_SLT))
            return ALU_SLT;
        if (op == `OP_LUI)
            return ALU_LUI;
        return ALU_ADD;
    endfunction

    // Nothing may write or flag while held in reset or in the IDLE cycle after release
    a_reset_quiet: assert property (@(posedge clk) (!reset || !$past(reset)) |->
        !(ctrl.ir_write || ctrl.mem_write || ctrl.data_write || ctrl.reg_write
          || ctrl.pc_write || ctrl.branch || ctrl.pc_en || illegal_instr))
    else report_mismatch("control word active around reset");

    // Fetch loads IR and writes PC + 4
    a_fetch_word: assert property (@(posedge clk) disable iff (!reset) ctrl.ir_write |->
        ctrl.pc_write && ctrl.alu_ctrl == ALU_ADD && ctrl.alu_src_b == `SRCB_FOUR)
    else report_mismatch("fetch cycle without PC + 4 update");

    // Register file outputs are latched in the cycle right after every fetch
    a_decode_latch: assert property (@(posedge clk) disable iff (!reset)
        ctrl.rdx_en == $past(ctrl.ir_write))
    else report_mismatch("rdx_en not high exactly in the cycle after fetch");

    // EXECUTE of an ALU instruction, two cycles after its fetch
    // R-type takes operand B from the register, I-type from the immediate
    a_alu_execute: assert property (@(posedge clk) disable iff (!reset)
        $past(ctrl.ir_write, 2) && alu_instr($past(opcode, 2), $past(funct, 2)) |->
        ctrl.alu_ctrl == expected_alu_op($past(opcode, 2), $past(funct, 2))
        && ctrl.reg_dst_rd == ($past(opcode, 2) == `OP_RTYPE)
        && ctrl.alu_src_b == (($past(opcode, 2) == `OP_RTYPE) ? `SRCB_REG : `SRCB_IMM)
        && ctrl.imm_zero_ext == ($past(opcode, 2) inside {`OP_ANDI, `OP_ORI})
        && ctrl.alu_result_en)
    else report_mismatch("wrong ALU operation, operand or extension select in EXECUTE");

    // Third cycle after fetch carries the register or memory write of the class
    a_cycle3_writes: assert property (@(posedge clk) disable iff (!reset)
        $past(ctrl.ir_write, 3) |->
        ctrl.reg_write == alu_instr($past(opcode, 3), $past(funct, 3))
        && ctrl.mem_write == ($past(opcode, 3) == `OP_SW)
        && ctrl.data_write == ($past(opcode, 3) == `OP_LW)
        && (!(ctrl.mem_write || ctrl.data_write) || (ctrl.iord && ctrl.mem_select))
        && (!ctrl.reg_write || !ctrl.mem_to_reg))
    else report_mismatch("wrong write enables three cycles after fetch");

    // A load writes memory data back in RETIRE
    a_load_retire: assert property (@(posedge clk) disable iff (!reset)
        $past(ctrl.ir_write, 4) && $past(opcode, 4) == `OP_LW |->
        ctrl.reg_write && ctrl.mem_to_reg)
    else report_mismatch("load without register write from memory");

    a_write_window: assert property (@(posedge clk) disable iff (!reset)
        (ctrl.reg_write || ctrl.mem_write || ctrl.data_write) |->
        $past(ctrl.ir_write, 3) || ($past(ctrl.ir_write, 4) && $past(opcode, 4) == `OP_LW))
    else report_mismatch("write enable outside its cycle");

    // Compare cycle of beq and bne follows zero in the proper sense
    a_branch_compare: assert property (@(posedge clk) disable iff (!reset)
        $past(ctrl.ir_write, 3) && ($past(opcode, 3) inside {`OP_BEQ, `OP_BNE}) |->
        ctrl.pc_src && ctrl.alu_ctrl == ALU_SUB
        && ctrl.branch == (($past(opcode, 3) == `OP_BEQ) ? zero : !zero)
        && ctrl.pc_en == ctrl.branch)
    else report_mismatch("wrong branch decision in compare cycle");

    a_branch_only: assert property (@(posedge clk) disable iff (!reset) ctrl.branch |->
        $past(ctrl.ir_write, 3) && ($past(opcode, 3) inside {`OP_BEQ, `OP_BNE}))
    else report_mismatch("branch high outside a compare cycle");

    // PC is written by fetch and by the JUMP state of j, nowhere else
    a_pc_write: assert property (@(posedge clk) disable iff (!reset)
        ctrl.pc_write
        == (ctrl.ir_write || ($past(ctrl.ir_write, 2) && $past(opcode, 2) == `OP_J)))
    else report_mismatch("pc_write does not match fetch or jump");

    a_illegal_flag: assert property (@(posedge clk) disable iff (!reset)
        illegal_instr
        == ($past(ctrl.ir_write, 2) && !defined_instr($past(opcode, 2), $past(funct, 2))))
    else report_mismatch("illegal_instr does not match an undefined instruction");

    // An undefined instruction is followed by a new fetch after four cycles
    a_undef_refetch: assert property (@(posedge clk) disable iff (!reset)
        $past(ctrl.ir_write, 4) && !defined_instr($past(opcode, 4), $past(funct, 4)) |->
        ctrl.ir_write)
    else report_mismatch("no fetch four cycles after an undefined instruction");

endmodule

// ==== logic/mips_control_top.sv ====
`timescale 1ns/1ns
`include "mips_control_consts.svh"

// Control unit of the multicycle processor
// Opcode and funct come from the instruction register, zero from the ALU
module mips_control_top
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`OPCODE_W-1:0]         opcode,
    input  logic [`FUNCT_W-1:0]          funct,
    input  logic                         zero,
    output mips_control_pkg::ctrl_word_t ctrl,
    output logic                         illegal_instr
);

    import mips_control_pkg::*;

    // Decode result shared by the sequencer and the generator
    decode_info_t info;
    // Current machine state
    ctrl_state_e  state;

    instr_decoder instr_decoder_i
    (
        .opcode (opcode),
        .funct  (funct),
        .info   (info)
    );

    state_sequencer state_sequencer_i
    (
        .clk           (clk),
        .reset         (reset),
        .info          (info),
        .state         (state),
        .illegal_instr (illegal_instr)
    );

    control_word_gen control_word_gen_i
    (
        .state (state),
        .info  (info),
        .zero  (zero),
        .ctrl  (ctrl)
    );

endmodule

// ==== logic/control_word_gen.sv ====
`timescale 1ns/1ns
`include "mips_control_consts.svh"

// Moore style output decode of the state, except for branch which also follows zero
module control_word_gen
(
    input  mips_control_pkg::ctrl_state_e  state,
    input  mips_control_pkg::decode_info_t info,
    input  logic                           zero,
    output mips_control_pkg::ctrl_word_t   ctrl
);

    import mips_control_pkg::*;

    always_comb
    begin
        // Everything idle unless the state below asks for it
        ctrl            = '0;
        ctrl.alu_ctrl   = ALU_AND;
        ctrl.alu_src_b  = `SRCB_REG;
        // Destination and extension selects just follow the decoder
        ctrl.reg_dst_rd   = info.reg_dst_rd;
        ctrl.imm_zero_ext = info.imm_zero_ext;

        case (state)
            FETCH:
            begin
                // Read instruction memory at PC and compute PC + 4 in the same cycle
                ctrl.ir_write  = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.alu_src_a = 1'b0;
                ctrl.alu_src_b = `SRCB_FOUR;
                ctrl.alu_ctrl  = ALU_ADD;
            end
            DECODE:
            begin
                // Latch both register file read ports
                ctrl.rdx_en = 1'b1;
            end
            EXECUTE:
            begin
                // Register A against whatever operand B the decoder chose
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = info.alu_src_b;
                ctrl.alu_ctrl      = info.alu_op;
                ctrl.alu_result_en = 1'b1;
            end
            WRITE_BACK:
            begin
                // ALU result register goes to the register file
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b0;
            end
            ADDR_CALC:
            begin
                // Effective address is base register plus offset
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = `SRCB_IMM;
                ctrl.alu_ctrl      = ALU_ADD;
                ctrl.alu_result_en = 1'b1;
            end
            STORE:
            begin
                // Data memory addressed by ALU out
                ctrl.iord       = 1'b1;
                ctrl.mem_select = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            LOAD:
            begin
                // Read data memory into the data latch
                ctrl.iord       = 1'b1;
                ctrl.mem_select = 1'b1;
                ctrl.data_write = 1'b1;
            end
            RETIRE:
            begin
                // Only a load still has a register to write, and it comes from memory
                if (info.instr_class == CLASS_LOAD)
                begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end
            end
            BRANCH_ADDR:
            begin
                // Target is PC + 4 plus the shifted offset, held in ALU out
                ctrl.alu_src_a     = 1'b0;
                ctrl.alu_src_b     = `SRCB_BR_OFFSET;
                ctrl.alu_ctrl      = ALU_ADD;
                ctrl.alu_result_en = 1'b1;
            end
            BEQ_COMPARE, BNE_COMPARE:
            begin
                // Subtract the registers, zero tells whether they match
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = `SRCB_REG;
                ctrl.alu_ctrl  = ALU_SUB;
                // PC loads from ALU out, which still holds the branch target
                ctrl.pc_src    = 1'b1;
                ctrl.branch    = (state == BEQ_COMPARE) ? zero : ~zero;
            end
            JUMP:
            begin
                ctrl.pc_write = 1'b1;
            end
            default:
            begin
                // IDLE, UPDATE_PC and UNDEFINED leave every enable low
                ctrl.pc_write = 1'b0;
            end
        endcase

        // PC register loads on an unconditional write or a taken branch
        ctrl.pc_en = ctrl.branch | ctrl.pc_write;
    end

    // Checked on each state change, against the settled inputs of the state just left
    // EXECUTE passes the decoded op through, so the decode must still be an ALU instruction
    a_execute_alu_class: assert property (
        @(state) (state == EXECUTE) |-> (info.instr_class == CLASS_ALU)
    )
    else $error("EXECUTE driven with a decode that is not an ALU instruction");

    // The compare state and the decode agree on beq or bne
    a_compare_class: assert property (
        @(state) (state inside {BEQ_COMPARE, BNE_COMPARE}) |->
        (info.instr_class == ((state == BEQ_COMPARE) ? CLASS_BEQ : CLASS_BNE))
    )
    else $error("compare state does not match the decoded branch");

endmodule

// ==== logic/state_sequencer.sv ====
`timescale 1ns/1ns

// State register of the multicycle machine
// DECODE, ADDR_CALC and BRANCH_ADDR are the only states that look at the decode result
module state_sequencer
(
    input  logic                           clk,
    input  logic                           reset,
    input  mips_control_pkg::decode_info_t info,
    output mips_control_pkg::ctrl_state_e  state,
    output logic                           illegal_instr
);

    import mips_control_pkg::*;

    ctrl_state_e next_state;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        case (state)
            IDLE:        next_state = FETCH;
            FETCH:       next_state = DECODE;
            DECODE:
            begin
                // The class alone picks the path, opcode is not looked at again
                case (info.instr_class)
                    CLASS_ALU:   next_state = EXECUTE;
                    CLASS_LOAD:  next_state = ADDR_CALC;
                    CLASS_STORE: next_state = ADDR_CALC;
                    CLASS_BEQ:   next_state = BRANCH_ADDR;
                    CLASS_BNE:   next_state = BRANCH_ADDR;
                    CLASS_JUMP:  next_state = JUMP;
                    default:     next_state = UNDEFINED;
                endcase
            end
            EXECUTE:     next_state = WRITE_BACK;
            WRITE_BACK:  next_state = RETIRE;
            ADDR_CALC:
            begin
                // Loads need the data latch cycle, stores write memory directly
                next_state = (info.instr_class == CLASS_LOAD) ? LOAD : STORE;
            end
            LOAD:        next_state = RETIRE;
            STORE:       next_state = RETIRE;
            BRANCH_ADDR:
            begin
                next_state = (info.instr_class == CLASS_BEQ) ? BEQ_COMPARE : BNE_COMPARE;
            end
            BEQ_COMPARE: next_state = RETIRE;
            BNE_COMPARE: next_state = RETIRE;
            JUMP:        next_state = UPDATE_PC;
            UPDATE_PC:   next_state = RETIRE;
            RETIRE:      next_state = FETCH;
            // Undefined instructions pass through IDLE so fetch restarts cleanly
            UNDEFINED:   next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // Flag is a plain state decode, high for the single UNDEFINED cycle
    assign illegal_instr = (state == UNDEFINED);

    // The load or store choice in ADDR_CALC relies on opcode held since DECODE
    a_addr_calc_class: assert property (
        @(posedge clk) disable iff (!reset)
        (state == ADDR_CALC) |-> (info.instr_class inside {CLASS_LOAD, CLASS_STORE})
    )
    else $error("ADDR_CALC reached without a load or store decode");

    // Same for the beq or bne choice in BRANCH_ADDR
    a_branch_addr_class: assert property (
        @(posedge clk) disable iff (!reset)
        (state == BRANCH_ADDR) |-> (info.instr_class inside {CLASS_BEQ, CLASS_BNE})
    )
    else $error("BRANCH_ADDR reached without a branch decode");

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ns
`include "mips_control_consts.svh"

// Purely combinational, the result follows opcode and funct in the same cycle
module instr_decoder
(
    input  logic [`OPCODE_W-1:0]           opcode,
    input  logic [`FUNCT_W-1:0]            funct,
    output mips_control_pkg::decode_info_t info
);

    import mips_control_pkg::*;

    // Decode result for anything the machine does not implement
    localparam decode_info_t UNDEF_INFO = '{
        instr_class  : CLASS_UNDEF,
        alu_op       : ALU_AND,
        alu_src_b    : `SRCB_REG,
        reg_dst_rd   : 1'b0,
        imm_zero_ext : 1'b0
    };

    always_comb
    begin
        info = UNDEF_INFO;
        case (opcode)
            `OP_RTYPE:
            begin
                // Register-register ops write rd and take B from the register file
                info.instr_class = CLASS_ALU;
                info.alu_src_b   = `SRCB_REG;
                info.reg_dst_rd  = 1'b1;
                case (funct)
                    `FN_ADD: info.alu_op = ALU_ADD;
                    `FN_SUB: info.alu_op = ALU_SUB;
                    `FN_AND: info.alu_op = ALU_AND;
                    `FN_OR:  info.alu_op = ALU_OR;
                    `FN_SLT: info.alu_op = ALU_SLT;
                    default:
                    begin
                        // An unknown funct makes the whole instruction undefined
                        info = UNDEF_INFO;
                    end
                endcase
            end
            `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI:
            begin
                // Immediate ops write rt and feed the immediate into operand B
                info.instr_class = CLASS_ALU;
                info.alu_src_b   = `SRCB_IMM;
                info.reg_dst_rd  = 1'b0;
                case (opcode)
                    `OP_ADDI: info.alu_op = ALU_ADD;
                    `OP_SLTI: info.alu_op = ALU_SLT;
                    `OP_ANDI: info.alu_op = ALU_AND;
                    `OP_ORI:  info.alu_op = ALU_OR;
                    default:  info.alu_op = ALU_LUI;
                endcase
                // Logical immediates are zero extended, arithmetic ones keep the sign
                info.imm_zero_ext = (opcode == `OP_ANDI) || (opcode == `OP_ORI);
            end
            `OP_LW:
            begin
                // Address is base plus sign extended offset
                info.instr_class = CLASS_LOAD;
                info.alu_op      = ALU_ADD;
                info.alu_src_b   = `SRCB_IMM;
            end
            `OP_SW:
            begin
                info.instr_class = CLASS_STORE;
                info.alu_op      = ALU_ADD;
                info.alu_src_b   = `SRCB_IMM;
            end
            `OP_BEQ:
            begin
                // Branches compare two registers by subtraction
                info.instr_class = CLASS_BEQ;
                info.alu_op      = ALU_SUB;
                info.alu_src_b   = `SRCB_REG;
            end
            `OP_BNE:
            begin
                info.instr_class = CLASS_BNE;
                info.alu_op      = ALU_SUB;
                info.alu_src_b   = `SRCB_REG;
            end
            `OP_J:
            begin
                // The jump target comes straight from the instruction, no ALU use
                info.instr_class = CLASS_JUMP;
            end
            default:
            begin
                info = UNDEF_INFO;
            end
        endcase
    end

endmodule

// ==== logic/mips_control_pkg.sv ====
package mips_control_pkg;

    // States of the multicycle machine
    // Every defined instruction walks FETCH, DECODE, two class states and RETIRE
    typedef enum logic [3:0]
    {
        IDLE        = 4'd0,
        FETCH       = 4'd1,
        DECODE      = 4'd2,
        EXECUTE     = 4'd3,
        WRITE_BACK  = 4'd4,
        ADDR_CALC   = 4'd5,
        LOAD        = 4'd6,
        STORE       = 4'd7,
        BRANCH_ADDR = 4'd8,
        BEQ_COMPARE = 4'd9,
        BNE_COMPARE = 4'd10,
        JUMP        = 4'd11,
        UPDATE_PC   = 4'd12,
        RETIRE      = 4'd13,
        UNDEFINED   = 4'd14
    } ctrl_state_e;

    // Operation codes understood by the datapath ALU
    typedef enum logic [3:0]
    {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_e;

    // Coarse instruction class, enough for the sequencer to pick its path
    typedef enum logic [2:0]
    {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BEQ,
        CLASS_BNE,
        CLASS_JUMP,
        CLASS_UNDEF
    } instr_class_e;

    // Result of decoding opcode and funct
    typedef struct packed
    {
        instr_class_e instr_class;
        alu_op_e      alu_op;
        // Operand B select wanted in EXECUTE
        logic [1:0]   alu_src_b;
        // High when the destination register is rd, low for rt
        logic         reg_dst_rd;
        // High when the immediate is zero extended instead of sign extended
        logic         imm_zero_ext;
    } decode_info_t;

    // Control word driven into the datapath every cycle
    typedef struct packed
    {
        logic       iord;
        logic       mem_write;
        logic       mem_select;
        logic       ir_write;
        logic       data_write;
        logic       reg_dst_rd;
        logic       mem_to_reg;
        logic       reg_write;
        logic       rdx_en;
        logic       alu_src_a;
        logic [1:0] alu_src_b;
        alu_op_e    alu_ctrl;
        logic       alu_result_en;
        logic       pc_src;
        logic       pc_write;
        logic       branch;
        logic       pc_en;
        logic       imm_zero_ext;
    } ctrl_word_t;

endpackage

// ==== include/mips_control_consts.svh ====
`ifndef MIPS_CONTROL_CONSTS_SVH
`define MIPS_CONTROL_CONSTS_SVH

// Instruction field widths as they leave the instruction register
`define OPCODE_W 6
`define FUNCT_W  6

// Primary opcodes of the supported instructions
// R-type instructions share opcode 0 and are told apart by funct
`define OP_RTYPE 6'd0
`define OP_J     6'd2
`define OP_BEQ   6'd4
`define OP_BNE   6'd5

// Immediate ALU group
`define OP_ADDI  6'd8
`define OP_SLTI  6'd10
`define OP_ANDI  6'd12
`define OP_ORI   6'd13
`define OP_LUI   6'd15

// Memory access group
`define OP_LW    6'd35
`define OP_SW    6'd43

// Funct codes accepted under the R-type opcode
`define FN_ADD   6'd32
`define FN_SUB   6'd34
`define FN_AND   6'd36
`define FN_OR    6'd37
`define FN_SLT   6'd42

// Select codes of the 4:1 mux in front of ALU operand B
// Register B from the register file read latch
`define SRCB_REG       2'd0
// Constant four for the PC increment
`define SRCB_FOUR      2'd1
// Extended immediate of an I-type instruction
`define SRCB_IMM       2'd2
// Immediate shifted left by two, used as branch displacement
`define SRCB_BR_OFFSET 2'd3

`endif
